//--- filelist.f
+incdir+hdl
hdl/csr_pkg.sv
hdl/csr_decode.sv
hdl/csr_execute.sv
hdl/csr_interrupt_ctrl.sv
hdl/csr_file_top.sv
test/tb_clock_gen.sv
test/csr_file_tb.sv

//--- hdl/csr_decode.sv
`timescale 1ns/10ps

module csr_decode import csr_pkg::*; (
    input  priv_lvl_e   prv_i,
    input  logic [11:0] chk_addr_i,
    input  csr_op_e     chk_op_i,
    output logic        chk_illegal_o,
    input  csr_addr_e   acc_addr_i,
    output csr_field_e  field_o
);

    logic known;
    logic illegal_ro;
    logic illegal_prv;

    // Legality of the check port
    always_comb begin
        case (csr_addr_e'(chk_addr_i))
            CSR_CYCLE, CSR_INSTRET,
            CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID, CSR_MHARTID,
            CSR_MSTATUS, CSR_MISA, CSR_MIE, CSR_MTVEC,
            CSR_MSCRATCH, CSR_MEPC, CSR_MCAUSE, CSR_MTVAL, CSR_MIP,
            CSR_MCYCLE, CSR_MINSTRET: known = 1'b1;
            default: known = 1'b0;
        endcase

        // Top two address bits of 11 mark a read-only CSR
        illegal_ro  = (chk_addr_i[11:10] == 2'b11) && (chk_op_i != CSR_OP_NONE);
        illegal_prv = chk_addr_i[9:8] > 2'(prv_i);

        chk_illegal_o = !known || illegal_ro || illegal_prv;
    end

    // Address to register select for the access port
    always_comb begin
        case (acc_addr_i)
            CSR_CYCLE:     field_o = FIELD_CYCLE;
            CSR_INSTRET:   field_o = FIELD_INSTRET;
            CSR_MVENDORID,
            CSR_MARCHID,
            CSR_MIMPID:    field_o = FIELD_ZERO;
            CSR_MHARTID:   field_o = FIELD_MHARTID;
            CSR_MSTATUS:   field_o = FIELD_MSTATUS;
            CSR_MISA:      field_o = FIELD_MISA;
            CSR_MIE:       field_o = FIELD_MIE;
            CSR_MTVEC:     field_o = FIELD_MTVEC;
            CSR_MSCRATCH:  field_o = FIELD_MSCRATCH;
            CSR_MEPC:      field_o = FIELD_MEPC;
            CSR_MCAUSE:    field_o = FIELD_MCAUSE;
            CSR_MTVAL:     field_o = FIELD_MTVAL;
            CSR_MIP:       field_o = FIELD_MIP;
            CSR_MCYCLE:    field_o = FIELD_MCYCLE;
            CSR_MINSTRET:  field_o = FIELD_MINSTRET;
            default:       field_o = FIELD_NONE;
        endcase
    end

endmodule

//--- hdl/csr_defs.svh
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// Data width of the hart
`define CSR_XLEN 64

// Interrupt bit positions in mie and mip
`define CSR_BIT_MEI 11
`define CSR_BIT_MTI 7
`define CSR_BIT_MSI 3

// Writable bits of mie
`define CSR_MIE_MASK 12'h888

// MXL = 2 with the A, C, I, M and U extensions
`define CSR_MISA_VALUE 64'h8000_0000_0010_1105

// Field positions within mstatus
`define CSR_MSTATUS_MIE 3
`define CSR_MSTATUS_MPIE 7
`define CSR_MSTATUS_MPP 12:11

// Exception code width in mcause
`define CSR_CAUSE_W 4

`endif

//--- hdl/csr_execute.sv
`timescale 1ns/10ps
`include "csr_defs.svh"

module csr_execute import csr_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  csr_req_t             acc_i,
    input  csr_field_e           field_i,
    input  trap_req_t            trap_i,
    input  logic                 mret_i,
    // {external, timer, software}
    input  logic [2:0]           irq_lines_i,
    input  logic                 instret_i,
    input  logic [`CSR_XLEN-1:0] hart_id_i,
    output logic [`CSR_XLEN-1:0] rdata_o,
    output logic [`CSR_XLEN-1:0] tvec_o,
    output logic [`CSR_XLEN-1:0] epc_o,
    output priv_lvl_e            prv_o,
    output irq_state_t           next_o
);

    priv_lvl_e               prv, prv_d;
    mstatus_t                mstatus, mstatus_d;
    logic [11:0]             mie, mie_d;
    logic [11:0]             mip;
    logic [`CSR_XLEN-1:0]    mtvec, mtvec_d;
    logic [`CSR_XLEN-1:0]    mepc, mepc_d;
    logic [`CSR_XLEN-1:0]    mscratch, mscratch_d;
    logic                    mcause_irq, mcause_irq_d;
    logic [`CSR_CAUSE_W-1:0] mcause_code, mcause_code_d;
    logic [`CSR_XLEN-1:0]    mtval, mtval_d;
    logic [`CSR_XLEN-1:0]    mcycle, mcycle_d;
    logic [`CSR_XLEN-1:0]    minstret, minstret_d;

    logic [`CSR_XLEN-1:0]    mstatus_rd;
    logic [`CSR_XLEN-1:0]    old_value;
    logic [`CSR_XLEN-1:0]    new_value;

    // mip follows the interrupt lines directly
    always_comb begin
        mip = '0;
        mip[`CSR_BIT_MEI] = irq_lines_i[2];
        mip[`CSR_BIT_MTI] = irq_lines_i[1];
        mip[`CSR_BIT_MSI] = irq_lines_i[0];
    end

    always_comb begin
        mstatus_rd = '0;
        mstatus_rd[`CSR_MSTATUS_MIE]  = mstatus.mie;
        mstatus_rd[`CSR_MSTATUS_MPIE] = mstatus.mpie;
        mstatus_rd[`CSR_MSTATUS_MPP]  = mstatus.mpp;
    end

    // Read mux
    always_comb begin
        case (field_i)
            FIELD_MHARTID:  old_value = hart_id_i;
            FIELD_MSTATUS:  old_value = mstatus_rd;
            FIELD_MISA:     old_value = `CSR_MISA_VALUE;
            FIELD_MIE:      old_value = `CSR_XLEN'(mie);
            FIELD_MTVEC:    old_value = mtvec;
            FIELD_MSCRATCH: old_value = mscratch;
            FIELD_MEPC:     old_value = mepc;
            FIELD_MCAUSE:
                old_value = {mcause_irq, {(`CSR_XLEN-`CSR_CAUSE_W-1){1'b0}}, mcause_code};
            FIELD_MTVAL:    old_value = mtval;
            FIELD_MIP:      old_value = `CSR_XLEN'(mip);
            FIELD_MCYCLE,
            FIELD_CYCLE:    old_value = mcycle;
            FIELD_MINSTRET,
            FIELD_INSTRET:  old_value = minstret;
            default:        old_value = '0;
        endcase
    end

    assign rdata_o = old_value;

    always_comb begin
        case (acc_i.op)
            CSR_OP_WRITE: new_value = acc_i.wdata;
            CSR_OP_SET:   new_value = old_value | acc_i.wdata;
            CSR_OP_CLEAR: new_value = old_value & ~acc_i.wdata;
            default:      new_value = old_value;
        endcase
    end

    assign tvec_o = mtvec;
    assign epc_o  = mepc;

    // Next state: trap over mret over access
    always_comb begin
        prv_d         = prv;
        mstatus_d     = mstatus;
        mie_d         = mie;
        mtvec_d       = mtvec;
        mepc_d        = mepc;
        mscratch_d    = mscratch;
        mcause_irq_d  = mcause_irq;
        mcause_code_d = mcause_code;
        mtval_d       = mtval;
        mcycle_d      = mcycle + 1'b1;
        minstret_d    = instret_i ? minstret + 1'b1 : minstret;

        if (trap_i.valid) begin
            mepc_d         = trap_i.epc;
            mcause_irq_d   = trap_i.irq;
            mcause_code_d  = trap_i.code;
            mtval_d        = trap_i.tval;
            mstatus_d.mpie = mstatus.mie;
            mstatus_d.mie  = 1'b0;
            mstatus_d.mpp  = prv;
            prv_d          = PRIV_LVL_M;
        end else if (mret_i) begin
            prv_d          = mstatus.mpp;
            mstatus_d.mie  = mstatus.mpie;
            mstatus_d.mpie = 1'b1;
            mstatus_d.mpp  = PRIV_LVL_U;
        end else if (acc_i.valid && acc_i.op != CSR_OP_NONE) begin
            case (field_i)
                FIELD_MSTATUS: begin
                    mstatus_d.mie  = new_value[`CSR_MSTATUS_MIE];
                    mstatus_d.mpie = new_value[`CSR_MSTATUS_MPIE];
                    // Only U and M are legal MPP values
                    if (new_value[`CSR_MSTATUS_MPP] == 2'b00 ||
                        new_value[`CSR_MSTATUS_MPP] == 2'b11) begin
                        mstatus_d.mpp = priv_lvl_e'(new_value[`CSR_MSTATUS_MPP]);
                    end
                end
                FIELD_MIE:      mie_d = new_value[11:0] & `CSR_MIE_MASK;
                FIELD_MTVEC:    mtvec_d = {new_value[`CSR_XLEN-1:2], 2'b00};
                FIELD_MSCRATCH: mscratch_d = new_value;
                FIELD_MEPC:     mepc_d = {new_value[`CSR_XLEN-1:1], 1'b0};
                FIELD_MCAUSE: begin
                    mcause_irq_d  = new_value[`CSR_XLEN-1];
                    mcause_code_d = new_value[`CSR_CAUSE_W-1:0];
                end
                FIELD_MTVAL:    mtval_d = new_value;
                FIELD_MCYCLE:   mcycle_d = new_value;
                FIELD_MINSTRET: minstret_d = new_value;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            prv         <= PRIV_LVL_M;
            mstatus     <= '0;
            mie         <= '0;
            mtvec       <= '0;
            mepc        <= '0;
            mscratch    <= '0;
            mcause_irq  <= 1'b0;
            mcause_code <= '0;
            mtval       <= '0;
            mcycle      <= '0;
            minstret    <= '0;
        end else begin
            prv         <= prv_d;
            mstatus     <= mstatus_d;
            mie         <= mie_d;
            mtvec       <= mtvec_d;
            mepc        <= mepc_d;
            mscratch    <= mscratch_d;
            mcause_irq  <= mcause_irq_d;
            mcause_code <= mcause_code_d;
            mtval       <= mtval_d;
            mcycle      <= mcycle_d;
            minstret    <= minstret_d;
        end
    end

    assign prv_o = prv;

    assign next_o = '{
        mie:         mie_d,
        mip:         mip,
        prv:         prv_d,
        mstatus_mie: mstatus_d.mie
    };

endmodule

//--- hdl/csr_file_top.sv
`timescale 1ns/10ps
`include "csr_defs.svh"

module csr_file_top import csr_pkg::*; (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic [11:0]             chk_addr_i,
    input  csr_op_e                 chk_op_i,
    output logic                    chk_illegal_o,
    input  csr_req_t                acc_i,
    output logic [`CSR_XLEN-1:0]    rdata_o,
    input  trap_req_t               trap_i,
    output logic [`CSR_XLEN-1:0]    tvec_o,
    input  logic                    mret_i,
    output logic [`CSR_XLEN-1:0]    epc_o,
    input  logic                    irq_m_ext_i,
    input  logic                    irq_m_sw_i,
    input  logic                    irq_m_timer_i,
    input  logic                    instret_i,
    input  logic [`CSR_XLEN-1:0]    hart_id_i,
    output priv_lvl_e               priv_o,
    output logic                    int_valid_o,
    output logic [`CSR_CAUSE_W-1:0] int_cause_o,
    output logic                    wfi_valid_o
);

    csr_field_e field;
    irq_state_t next_state;

    csr_decode csr_decode_inst (
        .prv_i         (priv_o),
        .chk_addr_i    (chk_addr_i),
        .chk_op_i      (chk_op_i),
        .chk_illegal_o (chk_illegal_o),
        .acc_addr_i    (acc_i.addr),
        .field_o       (field)
    );

    csr_execute csr_execute_inst (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .acc_i       (acc_i),
        .field_i     (field),
        .trap_i      (trap_i),
        .mret_i      (mret_i),
        .irq_lines_i ({irq_m_ext_i, irq_m_timer_i, irq_m_sw_i}),
        .instret_i   (instret_i),
        .hart_id_i   (hart_id_i),
        .rdata_o     (rdata_o),
        .tvec_o      (tvec_o),
        .epc_o       (epc_o),
        .prv_o       (priv_o),
        .next_o      (next_state)
    );

    csr_interrupt_ctrl csr_interrupt_ctrl_inst (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .next_i      (next_state),
        .int_valid_o (int_valid_o),
        .int_cause_o (int_cause_o),
        .wfi_valid_o (wfi_valid_o)
    );

endmodule

//--- hdl/csr_interrupt_ctrl.sv
`timescale 1ns/10ps
`include "csr_defs.svh"

module csr_interrupt_ctrl import csr_pkg::*; (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  irq_state_t              next_i,
    output logic                    int_valid_o,
    output logic [`CSR_CAUSE_W-1:0] int_cause_o,
    output logic                    wfi_valid_o
);

    logic [11:0]             enabled;
    logic                    int_valid_d;
    logic                    wfi_valid_d;
    logic [`CSR_CAUSE_W-1:0] int_cause_d;

    always_comb begin
        enabled     = next_i.mip & next_i.mie;
        wfi_valid_d = |enabled;
        // Below M, machine interrupts are always globally enabled
        int_valid_d = wfi_valid_d && (next_i.prv == PRIV_LVL_U || next_i.mstatus_mie);

        if (enabled[`CSR_BIT_MEI]) begin
            int_cause_d = `CSR_CAUSE_W'(`CSR_BIT_MEI);
        end else if (enabled[`CSR_BIT_MSI]) begin
            int_cause_d = `CSR_CAUSE_W'(`CSR_BIT_MSI);
        end else if (enabled[`CSR_BIT_MTI]) begin
            int_cause_d = `CSR_CAUSE_W'(`CSR_BIT_MTI);
        end else begin
            int_cause_d = '0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            int_valid_o <= 1'b0;
            int_cause_o <= '0;
            wfi_valid_o <= 1'b0;
        end else begin
            int_valid_o <= int_valid_d;
            int_cause_o <= int_cause_d;
            wfi_valid_o <= wfi_valid_d;
        end
    end

endmodule

//--- hdl/csr_pkg.sv
`include "csr_defs.svh"

package csr_pkg;

    typedef enum logic [1:0] {
        PRIV_LVL_U = 2'b00,
        PRIV_LVL_M = 2'b11
    } priv_lvl_e;

    typedef enum logic [1:0] {
        CSR_OP_NONE,
        CSR_OP_WRITE,
        CSR_OP_SET,
        CSR_OP_CLEAR
    } csr_op_e;

    // Supported CSR addresses
    typedef enum logic [11:0] {
        CSR_CYCLE     = 12'hC00,
        CSR_INSTRET   = 12'hC02,
        CSR_MVENDORID = 12'hF11,
        CSR_MARCHID   = 12'hF12,
        CSR_MIMPID    = 12'hF13,
        CSR_MHARTID   = 12'hF14,
        CSR_MSTATUS   = 12'h300,
        CSR_MISA      = 12'h301,
        CSR_MIE       = 12'h304,
        CSR_MTVEC     = 12'h305,
        CSR_MSCRATCH  = 12'h340,
        CSR_MEPC      = 12'h341,
        CSR_MCAUSE    = 12'h342,
        CSR_MTVAL     = 12'h343,
        CSR_MIP       = 12'h344,
        CSR_MCYCLE    = 12'hB00,
        CSR_MINSTRET  = 12'hB02
    } csr_addr_e;

    // Register selected by decode; cycle and instret are read-only aliases
    typedef enum logic [4:0] {
        FIELD_NONE,
        FIELD_ZERO,
        FIELD_MHARTID,
        FIELD_MSTATUS,
        FIELD_MISA,
        FIELD_MIE,
        FIELD_MTVEC,
        FIELD_MSCRATCH,
        FIELD_MEPC,
        FIELD_MCAUSE,
        FIELD_MTVAL,
        FIELD_MIP,
        FIELD_MCYCLE,
        FIELD_MINSTRET,
        FIELD_CYCLE,
        FIELD_INSTRET
    } csr_field_e;

    typedef struct packed {
        logic                 valid;
        csr_addr_e            addr;
        csr_op_e              op;
        logic [`CSR_XLEN-1:0] wdata;
    } csr_req_t;

    typedef struct packed {
        logic                    valid;
        logic                    irq;
        logic [`CSR_CAUSE_W-1:0] code;
        logic [`CSR_XLEN-1:0]    tval;
        logic [`CSR_XLEN-1:0]    epc;
    } trap_req_t;

    typedef struct packed {
        logic      mie;
        logic      mpie;
        priv_lvl_e mpp;
    } mstatus_t;

    // Next-state view handed to the interrupt controller
    typedef struct packed {
        logic [11:0] mie;
        logic [11:0] mip;
        priv_lvl_e   prv;
        logic        mstatus_mie;
    } irq_state_t;

endpackage

//--- test/csr_file_tb.sv
`timescale 1ns/10ps
`include "csr_defs.svh"

module csr_file_tb import csr_pkg::*; ();

    // About 100 cycles of tests, with a wide margin
    localparam int MAX_CYCLES = 2000;

    logic                    clk;
    logic                    rst_n;
    logic [11:0]             chk_addr;
    csr_op_e                 chk_op;
    logic                    chk_illegal_o;
    csr_req_t                acc;
    logic [`CSR_XLEN-1:0]    rdata_o;
    trap_req_t               trap;
    logic [`CSR_XLEN-1:0]    tvec_o;
    logic                    mret;
    logic [`CSR_XLEN-1:0]    epc_o;
    logic                    irq_ext;
    logic                    irq_sw;
    logic                    irq_timer;
    logic                    instret;
    logic [`CSR_XLEN-1:0]    hart_id;
    priv_lvl_e               priv_o;
    logic                    int_valid_o;
    logic [`CSR_CAUSE_W-1:0] int_cause_o;
    logic                    wfi_valid_o;

    int          errors;
    int          checks;
    int          cycle_count;
    logic [31:0] lfsr_state;

    // Reference model of the architectural state
    priv_lvl_e            m_prv;
    logic                 m_mie_b;
    logic                 m_mpie;
    priv_lvl_e            m_mpp;
    logic [11:0]          m_mie;
    logic [`CSR_XLEN-1:0] m_mtvec;
    logic [`CSR_XLEN-1:0] m_mepc;
    logic [`CSR_XLEN-1:0] m_mscratch;
    logic [`CSR_XLEN-1:0] m_mcause;
    logic [`CSR_XLEN-1:0] m_mtval;

    tb_clock_gen tb_clock_gen_inst (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    csr_file_top csr_file_top_inst (
        .clk_i         (clk),
        .rst_ni        (rst_n),
        .chk_addr_i    (chk_addr),
        .chk_op_i      (chk_op),
        .chk_illegal_o (chk_illegal_o),
        .acc_i         (acc),
        .rdata_o       (rdata_o),
        .trap_i        (trap),
        .tvec_o        (tvec_o),
        .mret_i        (mret),
        .epc_o         (epc_o),
        .irq_m_ext_i   (irq_ext),
        .irq_m_sw_i    (irq_sw),
        .irq_m_timer_i (irq_timer),
        .instret_i     (instret),
        .hart_id_i     (hart_id),
        .priv_o        (priv_o),
        .int_valid_o   (int_valid_o),
        .int_cause_o   (int_cause_o),
        .wfi_valid_o   (wfi_valid_o)
    );

    // A request is never raised without some interrupt enabled
    assert property (@(posedge clk) disable iff (!rst_n) int_valid_o |-> wfi_valid_o)
        else begin
            errors++;
            $display("MISMATCH t=%0t wfi_valid_o got=0 exp=1 (int_valid_o high)", $time);
        end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit
    task automatic rand_bits(input int n, output logic [63:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[62:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
        end
    endtask

    function automatic logic [63:0] model_read(input csr_addr_e addr);
        logic [63:0] v;
        v = '0;
        case (addr)
            CSR_MHARTID:  v = hart_id;
            CSR_MISA:     v = `CSR_MISA_VALUE;
            CSR_MSTATUS: begin
                v[`CSR_MSTATUS_MIE]  = m_mie_b;
                v[`CSR_MSTATUS_MPIE] = m_mpie;
                v[`CSR_MSTATUS_MPP]  = m_mpp;
            end
            CSR_MIE:      v = 64'(m_mie);
            CSR_MTVEC:    v = m_mtvec;
            CSR_MSCRATCH: v = m_mscratch;
            CSR_MEPC:     v = m_mepc;
            CSR_MCAUSE:   v = m_mcause;
            CSR_MTVAL:    v = m_mtval;
            CSR_MIP: begin
                v[`CSR_BIT_MEI] = irq_ext;
                v[`CSR_BIT_MTI] = irq_timer;
                v[`CSR_BIT_MSI] = irq_sw;
            end
            default:      v = '0;
        endcase
        return v;
    endfunction

    // WARL rules applied to a written value
    task automatic model_write(input csr_addr_e addr, input logic [63:0] v);
        case (addr)
            CSR_MSTATUS: begin
                m_mie_b = v[`CSR_MSTATUS_MIE];
                m_mpie  = v[`CSR_MSTATUS_MPIE];
                if (v[`CSR_MSTATUS_MPP] == 2'b00 || v[`CSR_MSTATUS_MPP] == 2'b11)
                    m_mpp = priv_lvl_e'(v[`CSR_MSTATUS_MPP]);
            end
            CSR_MIE:      m_mie = v[11:0] & `CSR_MIE_MASK;
            CSR_MTVEC:    m_mtvec = v & ~64'h3;
            CSR_MSCRATCH: m_mscratch = v;
            CSR_MEPC:     m_mepc = v & ~64'h1;
            CSR_MCAUSE:   m_mcause = {v[63], {(`CSR_XLEN-`CSR_CAUSE_W-1){1'b0}}, v[3:0]};
            CSR_MTVAL:    m_mtval = v;
            default: ;
        endcase
    endtask

    // Starts and ends on a falling edge; rdata_o must show the old value
    task automatic csr_access(input csr_addr_e addr, input csr_op_e op,
                              input logic [63:0] wdata);
        logic [63:0] old_value;
        logic [63:0] new_value;
        old_value = model_read(addr);
        case (op)
            CSR_OP_WRITE: new_value = wdata;
            CSR_OP_SET:   new_value = old_value | wdata;
            CSR_OP_CLEAR: new_value = old_value & ~wdata;
            default:      new_value = old_value;
        endcase
        acc.valid = 1'b1;
        acc.addr  = addr;
        acc.op    = op;
        acc.wdata = wdata;
        #10;
        check_value($sformatf("rdata_o(%s)", addr.name()), rdata_o, old_value);
        @(posedge clk);
        if (op != CSR_OP_NONE)
            model_write(addr, new_value);
        @(negedge clk);
        acc.valid = 1'b0;
        acc.op    = CSR_OP_NONE;
    endtask

    // Samples before the next rising edge, returns on the falling edge after it
    task automatic read_csr(input csr_addr_e addr, output logic [63:0] data);
        acc.valid = 1'b1;
        acc.addr  = addr;
        acc.op    = CSR_OP_NONE;
        #10;
        data = rdata_o;
        @(negedge clk);
        acc.valid = 1'b0;
    endtask

    task automatic check_legal(input logic [11:0] addr, input csr_op_e op, input logic exp);
        chk_addr = addr;
        chk_op   = op;
        #10;
        check_value($sformatf("chk_illegal_o(%h)", addr), chk_illegal_o, exp);
        @(negedge clk);
    endtask

    task automatic enter_trap(input logic irq, input logic [3:0] code,
                              input logic [63:0] tval, input logic [63:0] epc);
        trap.valid = 1'b1;
        trap.irq   = irq;
        trap.code  = code;
        trap.tval  = tval;
        trap.epc   = epc;
        #10;
        check_value("tvec_o", tvec_o, m_mtvec);
        @(posedge clk);
        m_mepc   = epc;
        m_mcause = {irq, {(`CSR_XLEN-`CSR_CAUSE_W-1){1'b0}}, code};
        m_mtval  = tval;
        m_mpie   = m_mie_b;
        m_mie_b  = 1'b0;
        m_mpp    = m_prv;
        m_prv    = PRIV_LVL_M;
        @(negedge clk);
        trap.valid = 1'b0;
        check_value("priv_o", priv_o, m_prv);
    endtask

    task automatic do_mret();
        mret = 1'b1;
        #10;
        check_value("epc_o", epc_o, m_mepc);
        @(posedge clk);
        m_prv   = m_mpp;
        m_mie_b = m_mpie;
        m_mpie  = 1'b1;
        m_mpp   = PRIV_LVL_U;
        @(negedge clk);
        mret = 1'b0;
        check_value("priv_o", priv_o, m_prv);
    endtask

    // Registered interrupt outputs against the model state
    task automatic check_interrupts();
        logic [11:0] enabled;
        logic [3:0]  cause;
        enabled = model_read(CSR_MIP) & m_mie;
        if (enabled[`CSR_BIT_MEI])
            cause = 4'(`CSR_BIT_MEI);
        else if (enabled[`CSR_BIT_MSI])
            cause = 4'(`CSR_BIT_MSI);
        else if (enabled[`CSR_BIT_MTI])
            cause = 4'(`CSR_BIT_MTI);
        else
            cause = 4'd0;
        check_value("wfi_valid_o", wfi_valid_o, |enabled);
        check_value("int_valid_o", int_valid_o,
                    (|enabled) && (m_prv == PRIV_LVL_U || m_mie_b));
        check_value("int_cause_o", int_cause_o, cause);
    endtask

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, checks: %0d, errors: %0d", MAX_CYCLES, checks, errors);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin : stimulus
        logic [63:0] r;
        logic [63:0] c0;
        logic [63:0] c1;
        int          n;
        int          ones;
        errors     = 0;
        checks     = 0;
        lfsr_state = 32'h49bed5a0;
        chk_addr   = '0;
        chk_op     = CSR_OP_NONE;
        acc        = '0;
        trap       = '0;
        mret       = 1'b0;
        irq_ext    = 1'b0;
        irq_sw     = 1'b0;
        irq_timer  = 1'b0;
        instret    = 1'b0;
        rand_bits(64, hart_id);
        m_prv      = PRIV_LVL_M;
        m_mie_b    = 1'b0;
        m_mpie     = 1'b0;
        m_mpp      = PRIV_LVL_U;
        m_mie      = '0;
        m_mtvec    = '0;
        m_mepc     = '0;
        m_mscratch = '0;
        m_mcause   = '0;
        m_mtval    = '0;
        @(posedge rst_n);
        @(negedge clk);

        // Reset state
        check_value("priv_o", priv_o, PRIV_LVL_M);
        check_value("int_valid_o", int_valid_o, 1'b0);
        check_value("wfi_valid_o", wfi_valid_o, 1'b0);
        csr_access(CSR_MISA, CSR_OP_NONE, '0);
        csr_access(CSR_MHARTID, CSR_OP_NONE, '0);
        csr_access(CSR_MSCRATCH, CSR_OP_NONE, '0);

        // Read-modify-write and WARL masking
        rand_bits(64, r);
        csr_access(CSR_MSCRATCH, CSR_OP_WRITE, r);
        rand_bits(64, r);
        csr_access(CSR_MSCRATCH, CSR_OP_SET, r);
        rand_bits(64, r);
        csr_access(CSR_MSCRATCH, CSR_OP_CLEAR, r);
        csr_access(CSR_MSCRATCH, CSR_OP_NONE, '0);
        rand_bits(64, r);
        csr_access(CSR_MTVEC, CSR_OP_WRITE, r | 64'h3);
        csr_access(CSR_MTVEC, CSR_OP_NONE, '0);
        rand_bits(64, r);
        csr_access(CSR_MEPC, CSR_OP_WRITE, r | 64'h1);
        csr_access(CSR_MEPC, CSR_OP_NONE, '0);
        rand_bits(64, r);
        csr_access(CSR_MIE, CSR_OP_WRITE, r);
        csr_access(CSR_MIE, CSR_OP_NONE, '0);
        rand_bits(64, r);
        csr_access(CSR_MISA, CSR_OP_WRITE, r);
        csr_access(CSR_MISA, CSR_OP_NONE, '0);
        csr_access(CSR_MIP, CSR_OP_SET, '1);
        csr_access(CSR_MIP, CSR_OP_NONE, '0);

        // Privilege checks in M, then in U after an MRET with MPP = U
        check_legal(CSR_MVENDORID, CSR_OP_WRITE, 1'b1);
        check_legal(12'h345, CSR_OP_NONE, 1'b1);
        check_legal(CSR_MSCRATCH, CSR_OP_WRITE, 1'b0);
        do_mret();
        check_value("priv_o", priv_o, PRIV_LVL_U);
        check_legal(CSR_MSCRATCH, CSR_OP_NONE, 1'b1);
        check_legal(CSR_CYCLE, CSR_OP_NONE, 1'b0);

        // Trap from U, return with MPP = M and MPIE set, trap again from M with MIE set
        rand_bits(5, r);
        rand_bits(64, c0);
        rand_bits(64, c1);
        enter_trap(r[4], r[3:0], c0, c1);
        csr_access(CSR_MEPC, CSR_OP_NONE, '0);
        csr_access(CSR_MCAUSE, CSR_OP_NONE, '0);
        csr_access(CSR_MTVAL, CSR_OP_NONE, '0);
        csr_access(CSR_MSTATUS, CSR_OP_SET, 64'h1888);
        do_mret();
        rand_bits(5, r);
        rand_bits(64, c0);
        rand_bits(64, c1);
        enter_trap(r[4], r[3:0], c0, c1);
        csr_access(CSR_MSTATUS, CSR_OP_NONE, '0);
        csr_access(CSR_MCAUSE, CSR_OP_NONE, '0);

        // Interrupts with random lines
        csr_access(CSR_MIE, CSR_OP_WRITE, '1);
        csr_access(CSR_MSTATUS, CSR_OP_SET, 64'h8);
        rand_bits(3, r);
        for (int i = 0; i < 8; i++) begin
            // Every line combination once, in a random order
            {irq_ext, irq_timer, irq_sw} = r[2:0] ^ 3'(i);
            @(posedge clk);
            @(negedge clk);
            check_interrupts();
        end
        {irq_ext, irq_timer, irq_sw} = 3'b111;
        csr_access(CSR_MSTATUS, CSR_OP_CLEAR, 64'h8);
        check_value("int_valid_o", int_valid_o, 1'b0);
        check_value("wfi_valid_o", wfi_valid_o, 1'b1);
        {irq_ext, irq_timer, irq_sw} = 3'b000;

        // mcycle over a random gap
        rand_bits(4, r);
        n = int'(r) + 1;
        read_csr(CSR_MCYCLE, c0);
        repeat (n - 1) @(negedge clk);
        read_csr(CSR_MCYCLE, c1);
        check_value("mcycle delta", c1 - c0, 64'(n));

        // minstret counts only retiring cycles
        read_csr(CSR_MINSTRET, c0);
        ones = 0;
        for (int i = 0; i < 16; i++) begin
            rand_bits(1, r);
            instret = r[0];
            ones += int'(r[0]);
            @(posedge clk);
            @(negedge clk);
        end
        instret = 1'b0;
        read_csr(CSR_MINSTRET, c1);
        check_value("minstret delta", c1 - c0, 64'(ones));

        // Written mcycle restarts the count
        rand_bits(64, r);
        acc.valid = 1'b1;
        acc.addr  = CSR_MCYCLE;
        acc.op    = CSR_OP_WRITE;
        acc.wdata = r;
        @(posedge clk);
        @(negedge clk);
        acc.valid = 1'b0;
        acc.op    = CSR_OP_NONE;
        read_csr(CSR_MCYCLE, c0);
        check_value("mcycle", c0, r);
        repeat (4) @(negedge clk);
        read_csr(CSR_MCYCLE, c1);
        check_value("mcycle", c1, r + 64'd5);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- test/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic rst_no
);

    // 100 ns period
    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;
    end

    // Release on a falling edge, away from the sampling edge
    initial begin
        rst_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_no = 1'b1;
    end

endmodule
